// File: logic/video_pkg.sv
// raster timing constants and coordinate types for the video subsystem
// imported by the timing generator, the layer control and the tile layers

`default_nettype none

package video_pkg;

    // horizontal timing, in clocks (one pixel per clock)
    localparam int H_TOTAL  = 64;
    localparam int H_ACTIVE = 48;
    localparam int HS_START = 52;
    localparam int HS_WIDTH = 4;

    // vertical timing, in lines
    localparam int V_TOTAL  = 40;
    localparam int V_ACTIVE = 32;
    localparam int VS_START = 34;
    localparam int VS_WIDTH = 2;

    // raw raster counters
    typedef logic [5:0] hpos_t;
    typedef logic [5:0] vpos_t;

    // scrolled coordinate, wraps modulo 256
    typedef logic [7:0] coord_t;

endpackage

`default_nettype wire

// File: logic/gfx_pkg.sv
// graphics side definitions: layer count, pixel and palette formats,
// colour channels, graphics ROM words and CPU register addresses

`default_nettype none

package gfx_pkg;

    localparam int NUM_LAYERS = 3;

    // 4-bit pixel code, 0 is transparent
    typedef logic [3:0] pixel_t;

    // palette index is {layer[1:0], pixel[3:0]}
    typedef logic [5:0] pal_idx_t;

    localparam int PAL_SIZE = 64;

    // layer field 3 with pixel 0
    localparam pal_idx_t BACKDROP_IDX = 6'd48;

    // xRGB555 palette word
    typedef logic [15:0] pal_entry_t;

    // expanded output channel
    typedef logic [7:0] chan_t;

    // word address is {y[7:0], x[7:3]}
    typedef logic [12:0] rom_addr_t;

    // eight 4-bit pixels per word, nibble 0 in bits 3:0
    typedef logic [31:0] rom_word_t;

    // layer_ctrl register map
    // addresses 0 to 5 hold scroll x and y of each layer in turn
    localparam int REG_ENABLE  = 6;
    localparam int REG_IRQ_ACK = 7;

endpackage

`default_nettype wire

// File: logic/video_timing.sv
// raster timing generator
// free-running pixel and line counters with sync, blanking and the
// vblank start pulse used for the CPU interrupt

`timescale 1ns/1ps
`default_nettype none

module video_timing
    import video_pkg::*;
(
    input  wire   clk,
    input  wire   reset,
    output hpos_t hdump,
    output vpos_t vdump,
    output logic  lhbl,
    output logic  lvbl,
    output logic  hs,
    output logic  vs,
    output logic  vblank_start
);

    logic h_last;
    logic v_last;

    assign h_last = (hdump == hpos_t'(H_TOTAL - 1));
    assign v_last = (vdump == vpos_t'(V_TOTAL - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            hdump <= '0;
            vdump <= '0;
        end else begin
            if (h_last) begin
                hdump <= '0;
                // line counter advances at the end of each line
                if (v_last) begin
                    vdump <= '0;
                end else begin
                    vdump <= vdump + 1'b1;
                end
            end else begin
                hdump <= hdump + 1'b1;
            end
        end
    end

    // visible area, high while drawing
    assign lhbl = (hdump < H_ACTIVE);
    assign lvbl = (vdump < V_ACTIVE);

    // active-high sync pulses
    assign hs = (hdump >= HS_START) && (hdump < HS_START + HS_WIDTH);
    assign vs = (vdump >= VS_START) && (vdump < VS_START + VS_WIDTH);

    // first clock of the first blank line
    assign vblank_start = (vdump == vpos_t'(V_ACTIVE)) && (hdump == '0);

    // counters wrap at their totals and never run past them
    a_counter_range: assert property (
        @(posedge clk) disable iff (reset)
        (int'(hdump) < H_TOTAL) && (int'(vdump) < V_TOTAL)
    );

endmodule

`default_nettype wire

// File: logic/layer_ctrl.sv
// CPU-written scroll, enable and interrupt registers
// registers the scrolled x and y of every layer each clock, along with
// the raster display enable that travels with them

`timescale 1ns/1ps
`default_nettype none

module layer_ctrl
    import video_pkg::*;
    import gfx_pkg::*;
(
    input  wire                    clk,
    input  wire                    reset,
    input  wire  [5:0]             cpu_addr,
    input  wire  [15:0]            cpu_dout,
    input  wire                    cpu_we,
    input  wire                    regs_cs,
    input  hpos_t                  hdump,
    input  vpos_t                  vdump,
    input  wire                    lhbl,
    input  wire                    lvbl,
    input  wire                    vblank_start,
    output coord_t                 layer_x [NUM_LAYERS],
    output coord_t                 layer_y [NUM_LAYERS],
    output logic [NUM_LAYERS-1:0]  layer_en,
    output logic                   raster_de,
    output logic                   irq_n
);

    coord_t                scroll_x [NUM_LAYERS];
    coord_t                scroll_y [NUM_LAYERS];
    logic [NUM_LAYERS-1:0] en_reg;
    logic                  reg_wr;

    assign reg_wr = regs_cs && cpu_we;

    // register file, even address is x and odd is y
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < NUM_LAYERS; k++) begin
                scroll_x[k] <= '0;
                scroll_y[k] <= '0;
            end
            en_reg <= '1;
        end else if (reg_wr) begin
            for (int k = 0; k < NUM_LAYERS; k++) begin
                if (int'(cpu_addr) == 2 * k) scroll_x[k] <= cpu_dout[7:0];
                if (int'(cpu_addr) == 2 * k + 1) scroll_y[k] <= cpu_dout[7:0];
            end
            if (int'(cpu_addr) == REG_ENABLE) en_reg <= cpu_dout[NUM_LAYERS-1:0];
        end
    end

    // interrupt held low from vblank until acknowledged
    always_ff @(posedge clk) begin
        if (reset) begin
            irq_n <= 1'b1;
        end else if (vblank_start) begin
            irq_n <= 1'b0;
        end else if (reg_wr && int'(cpu_addr) == REG_IRQ_ACK) begin
            irq_n <= 1'b1;
        end
    end

    // scrolled coordinates, sums wrap at 8 bits
    always_ff @(posedge clk) begin
        for (int k = 0; k < NUM_LAYERS; k++) begin
            layer_x[k] <= coord_t'(hdump) + scroll_x[k];
            layer_y[k] <= coord_t'(vdump) + scroll_y[k];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            raster_de <= 1'b0;
            layer_en  <= '1;
        end else begin
            raster_de <= lhbl && lvbl;
            layer_en  <= en_reg;
        end
    end

    // only the timing generator can raise the interrupt
    a_irq_source: assert property (
        @(posedge clk) disable iff (reset)
        $fell(irq_n) |-> $past(vblank_start)
    );

endmodule

`default_nettype wire

// File: logic/tile_layer.sv
// one tile layer: turns a scrolled coordinate into a graphics ROM word
// address and picks the 4-bit pixel out of the returned word
// the ROM answers in the same clock, the pixel is registered

`timescale 1ns/1ps
`default_nettype none

module tile_layer
    import video_pkg::*;
    import gfx_pkg::*;
(
    input  wire       clk,
    input  wire       reset,
    input  coord_t    x,
    input  coord_t    y,
    input  wire       en,
    input  wire       de_in,
    input  rom_word_t rom_data,
    output rom_addr_t rom_addr,
    output pixel_t    pxl,
    output logic      pxl_de
);

    logic [2:0] nib_sel;
    pixel_t     rom_pxl;

    // eight pixels per word, so x[7:3] picks the word within the row
    assign rom_addr = {y, x[7:3]};

    assign nib_sel = x[2:0];

    // nibble 0 sits in bits 3:0
    always_comb begin
        rom_pxl = rom_data[nib_sel * 4 +: 4];
    end

    // disabled layers and blanked pixels read as transparent
    always_ff @(posedge clk) begin
        if (en && de_in) begin
            pxl <= rom_pxl;
        end else begin
            pxl <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pxl_de <= 1'b0;
        end else begin
            pxl_de <= de_in;
        end
    end

endmodule

`default_nettype wire

// File: logic/color_mixer.sv
// colour mixer: picks the highest priority opaque layer pixel, looks it
// up in the CPU-writable palette and expands xRGB555 to 8-bit channels
// two register stages from layer pixels to RGB output

`timescale 1ns/1ps
`default_nettype none

module color_mixer
    import gfx_pkg::*;
(
    input  wire                   clk,
    input  wire                   reset,
    input  pixel_t                layer_pxl [NUM_LAYERS],
    input  wire  [NUM_LAYERS-1:0] pxl_de,
    input  wire  [5:0]            cpu_addr,
    input  pal_entry_t            cpu_dout,
    input  wire                   cpu_we,
    input  wire                   pal_cs,
    output pal_entry_t            pal_dout,
    output chan_t                 red,
    output chan_t                 green,
    output chan_t                 blue,
    output logic                  de
);

    pal_entry_t pal_ram [PAL_SIZE];
    pal_idx_t   prio_idx;
    pal_idx_t   pal_idx;
    pal_entry_t pal_q;
    logic       de_s1;

    function automatic chan_t expand5(input logic [4:0] c);
        expand5 = {c, c[4:2]};
    endfunction

    // lower layer number wins, so scan from the back and overwrite
    always_comb begin
        prio_idx = BACKDROP_IDX;
        for (int k = NUM_LAYERS - 1; k >= 0; k--) begin
            if (layer_pxl[k] != '0) begin
                prio_idx = {k[1:0], layer_pxl[k]};
            end
        end
    end

    // stage one, palette index
    always_ff @(posedge clk) begin
        pal_idx <= prio_idx;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            de_s1 <= 1'b0;
            de    <= 1'b0;
        end else begin
            // all layers carry the same enable
            de_s1 <= &pxl_de;
            de    <= de_s1;
        end
    end

    // CPU write port
    always_ff @(posedge clk) begin
        if (pal_cs && cpu_we) begin
            pal_ram[cpu_addr] <= cpu_dout;
        end
    end

    // CPU read port, data one clock after the request
    always_ff @(posedge clk) begin
        if (pal_cs && !cpu_we) begin
            pal_dout <= pal_ram[cpu_addr];
        end
    end

    // stage two, video lookup
    always_ff @(posedge clk) begin
        pal_q <= pal_ram[pal_idx];
    end

    // black while blanked
    assign red   = de ? expand5(pal_q[14:10]) : '0;
    assign green = de ? expand5(pal_q[9:5])   : '0;
    assign blue  = de ? expand5(pal_q[4:0])   : '0;

    // backdrop field is never paired with an opaque pixel
    a_backdrop_idx: assert property (
        @(posedge clk) disable iff (reset)
        (pal_idx[5:4] == 2'd3) |-> (pal_idx[3:0] == 4'd0)
    );

endmodule

`default_nettype wire

// File: logic/video_top.sv
// video subsystem top level
// connects the raster timing, the layer registers, the tile layers and
// the colour mixer; each layer has its own graphics ROM port

`timescale 1ns/1ps
`default_nettype none

module video_top
    import video_pkg::*;
    import gfx_pkg::*;
(
    input  wire         clk,
    input  wire         reset,
    input  wire  [5:0]  cpu_addr,
    input  wire  [15:0] cpu_dout,
    input  wire         cpu_we,
    input  wire         regs_cs,
    input  wire         pal_cs,
    input  rom_word_t   rom_data [NUM_LAYERS],
    output rom_addr_t   rom_addr [NUM_LAYERS],
    output pal_entry_t  pal_dout,
    output logic        hs,
    output logic        vs,
    output logic        lhbl,
    output logic        lvbl,
    output logic        irq_n,
    output chan_t       red,
    output chan_t       green,
    output chan_t       blue,
    output logic        de
);

    hpos_t                 hdump;
    vpos_t                 vdump;
    logic                  vblank_start;
    coord_t                layer_x [NUM_LAYERS];
    coord_t                layer_y [NUM_LAYERS];
    logic [NUM_LAYERS-1:0] layer_en;
    logic                  raster_de;
    pixel_t                layer_pxl [NUM_LAYERS];
    logic [NUM_LAYERS-1:0] layer_de;

    video_timing u_timing (
        .clk          (clk),
        .reset        (reset),
        .hdump        (hdump),
        .vdump        (vdump),
        .lhbl         (lhbl),
        .lvbl         (lvbl),
        .hs           (hs),
        .vs           (vs),
        .vblank_start (vblank_start)
    );

    layer_ctrl u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .cpu_addr     (cpu_addr),
        .cpu_dout     (cpu_dout),
        .cpu_we       (cpu_we),
        .regs_cs      (regs_cs),
        .hdump        (hdump),
        .vdump        (vdump),
        .lhbl         (lhbl),
        .lvbl         (lvbl),
        .vblank_start (vblank_start),
        .layer_x      (layer_x),
        .layer_y      (layer_y),
        .layer_en     (layer_en),
        .raster_de    (raster_de),
        .irq_n        (irq_n)
    );

    for (genvar k = 0; k < NUM_LAYERS; k++) begin : g_layer
        tile_layer u_layer (
            .clk      (clk),
            .reset    (reset),
            .x        (layer_x[k]),
            .y        (layer_y[k]),
            .en       (layer_en[k]),
            .de_in    (raster_de),
            .rom_data (rom_data[k]),
            .rom_addr (rom_addr[k]),
            .pxl      (layer_pxl[k]),
            .pxl_de   (layer_de[k])
        );
    end

    color_mixer u_mixer (
        .clk       (clk),
        .reset     (reset),
        .layer_pxl (layer_pxl),
        .pxl_de    (layer_de),
        .cpu_addr  (cpu_addr),
        .cpu_dout  (cpu_dout),
        .cpu_we    (cpu_we),
        .pal_cs    (pal_cs),
        .pal_dout  (pal_dout),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .de        (de)
    );

endmodule

`default_nettype wire

// File: verif/video_tb.sv
// testbench for the tile video subsystem
// runs a table of scroll, enable and palette settings, one frame per row,
// and compares every visible pixel with a model of the layer rules

`timescale 1ns/1ps
`default_nettype none

module video_tb
    import video_pkg::*;
    import gfx_pkg::*;
();

    typedef struct packed {
        logic [47:0] scroll;   // byte r is register r
        logic [2:0]  en;
        logic        refill;
    } frame_row_t;

    localparam int NUM_ROWS = 6;
    localparam int WAIT_LIMIT = 2 * V_TOTAL * H_TOTAL;
    localparam logic [31:0] SEED = 32'h62ff_246c;

    localparam frame_row_t ROWS [NUM_ROWS] = '{
        '{48'h00_00_00_00_00_00, 3'b111, 1'b1},
        '{48'h05_1b_30_02_11_07, 3'b111, 1'b0},
        '{48'h40_c3_0e_81_2d_10, 3'b110, 1'b0},
        '{48'h09_fa_e0_33_00_21, 3'b100, 1'b1},
        '{48'h11_22_33_44_55_66, 3'b000, 1'b0},
        '{48'hfe_fc_f8_e9_f1_f9, 3'b101, 1'b1}
    };

    logic        clk;
    logic        reset;
    logic [5:0]  cpu_addr;
    logic [15:0] cpu_dout;
    logic        cpu_we;
    logic        regs_cs;
    logic        pal_cs;
    rom_word_t   rom_data [NUM_LAYERS];
    rom_addr_t   rom_addr [NUM_LAYERS];
    pal_entry_t  pal_dout;
    logic        hs;
    logic        vs;
    logic        lhbl;
    logic        lvbl;
    logic        irq_n;
    chan_t       red;
    chan_t       green;
    chan_t       blue;
    logic        de;

    // reference state
    pal_entry_t  pal_model [PAL_SIZE];
    coord_t      cur_sx [NUM_LAYERS];
    coord_t      cur_sy [NUM_LAYERS];
    logic [2:0]  cur_en;
    logic [31:0] lfsr_state;
    int          errors;
    int          checks;
    int          tests;
    int          test_errors;
    logic        timed_out;

    video_top dut0 (
        .clk      (clk),
        .reset    (reset),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout),
        .cpu_we   (cpu_we),
        .regs_cs  (regs_cs),
        .pal_cs   (pal_cs),
        .rom_data (rom_data),
        .rom_addr (rom_addr),
        .pal_dout (pal_dout),
        .hs       (hs),
        .vs       (vs),
        .lhbl     (lhbl),
        .lvbl     (lvbl),
        .irq_n    (irq_n),
        .red      (red),
        .green    (green),
        .blue     (blue),
        .de       (de)
    );

    always #2 clk = ~clk;

    // graphics ROM contents, hashed from layer and full word address
    // the AND of two rotations leaves plenty of transparent nibbles
    function automatic rom_word_t rom_fill(input int layer, input rom_addr_t a);
        logic [31:0] h;
        h = {19'd0, a} * 32'h045d_9f3b + 32'(layer) * 32'h27d4_eb2d;
        h = h ^ (h >> 15);
        return h & {h[15:0], h[31:16]};
    endfunction

    for (genvar k = 0; k < NUM_LAYERS; k++) begin : g_rom
        assign rom_data[k] = rom_fill(k, rom_addr[k]);
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic chan_t expand_chan(input logic [4:0] c);
        return {c, c[4:2]};
    endfunction

    // first opaque pixel from layer 0 upwards, else the backdrop
    function automatic pal_idx_t expected_index(input int col, input int row);
        coord_t    x;
        coord_t    y;
        rom_word_t w;
        pixel_t    p;
        pal_idx_t  idx;
        logic      found;
        idx = BACKDROP_IDX;
        found = 1'b0;
        for (int k = 0; k < NUM_LAYERS; k++) begin
            x = coord_t'(col) + cur_sx[k];
            y = coord_t'(row) + cur_sy[k];
            w = rom_fill(k, {y, x[7:3]});
            p = w[int'(x[2:0]) * 4 +: 4];
            if (!found && cur_en[k] && p != 4'd0) begin
                idx = {k[1:0], p};
                found = 1'b1;
            end
        end
        return idx;
    endfunction

    task automatic check_eq(input string name, input int actual, input int expected);
        checks++;
        assert (actual == expected) else begin
            $display("** Error: time %0t: %s = 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        errors++;
        timed_out = 1'b1;
    endtask

    task automatic start_test();
        test_errors = errors;
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_errors) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - test_errors);
        end
    endtask

    task automatic reg_write(input logic [5:0] addr, input logic [15:0] data);
        @(negedge clk);
        regs_cs = 1'b1;
        cpu_we = 1'b1;
        cpu_addr = addr;
        cpu_dout = data;
        @(negedge clk);
        regs_cs = 1'b0;
        cpu_we = 1'b0;
    endtask

    task automatic wait_irq(input logic level);
        int n;
        n = 0;
        while (irq_n != level && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (irq_n != level) report_timeout("irq_n to change");
    endtask

    task automatic wait_de();
        int n;
        n = 0;
        while (!de && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!de) report_timeout("the first visible pixel");
    endtask

    // one full frame of counts from any starting point
    task automatic check_raster();
        int lhbl_line;
        int hs_line;
        int lvbl_total;
        int vs_total;
        int de_total;
        lvbl_total = 0;
        vs_total = 0;
        de_total = 0;
        for (int line = 0; line < V_TOTAL; line++) begin
            lhbl_line = 0;
            hs_line = 0;
            for (int p = 0; p < H_TOTAL; p++) begin
                @(negedge clk);
                if (lhbl) lhbl_line++;
                if (hs) hs_line++;
                if (lvbl) lvbl_total++;
                if (vs) vs_total++;
                if (de) de_total++;
            end
            check_eq("lhbl clocks per line", lhbl_line, H_ACTIVE);
            check_eq("hs clocks per line", hs_line, HS_WIDTH);
        end
        check_eq("lvbl clocks per frame", lvbl_total, V_ACTIVE * H_TOTAL);
        check_eq("vs clocks per frame", vs_total, VS_WIDTH * H_TOTAL);
        check_eq("de clocks per frame", de_total, H_ACTIVE * V_ACTIVE);
    endtask

    // write fresh random entries, then read all back in a pipelined sweep
    task automatic refill_palette();
        pal_entry_t w;
        for (int i = 0; i < PAL_SIZE; i++) begin
            w = '0;
            for (int b = 0; b < 16; b++) begin
                lfsr_state = lfsr_next(lfsr_state);
                w = {w[14:0], lfsr_state[0]};
            end
            pal_model[i] = w;
            @(negedge clk);
            pal_cs = 1'b1;
            cpu_we = 1'b1;
            cpu_addr = 6'(i);
            cpu_dout = w;
        end
        for (int i = 0; i <= PAL_SIZE; i++) begin
            @(negedge clk);
            if (i > 0) check_eq("pal_dout", int'(pal_dout), int'(pal_model[i-1]));
            cpu_we = 1'b0;
            pal_cs = (i < PAL_SIZE);
            cpu_addr = 6'(i % PAL_SIZE);
        end
        pal_cs = 1'b0;
    endtask

    task automatic capture_frame();
        int         col;
        int         row;
        int         n;
        int         irq_low;
        pal_entry_t v;
        col = 0;
        row = 0;
        n = 0;
        irq_low = 0;
        wait_de();
        if (timed_out) return;
        while (row < V_ACTIVE && n < WAIT_LIMIT) begin
            if (!irq_n) irq_low++;
            if (de) begin
                v = pal_model[expected_index(col, row)];
                check_eq("red", int'(red), int'(expand_chan(v[14:10])));
                check_eq("green", int'(green), int'(expand_chan(v[9:5])));
                check_eq("blue", int'(blue), int'(expand_chan(v[4:0])));
                col++;
                if (col == H_ACTIVE) begin
                    col = 0;
                    row++;
                end
            end else begin
                // blanked pixels come out black
                check_eq("rgb while blanked", int'({red, green, blue}), 0);
            end
            @(negedge clk);
            n++;
        end
        if (row < V_ACTIVE) begin
            report_timeout("the end of the visible frame");
            return;
        end
        check_eq("de after last pixel", int'(de), 0);
        check_eq("irq_n low clocks in frame", irq_low, 0);
    endtask

    task automatic run_row(input int r);
        start_test();
        wait_irq(1'b0);
        if (timed_out) begin
            end_test($sformatf("irq row %0d", r));
            return;
        end
        check_eq("lvbl at irq_n fall", int'(lvbl), 0);
        for (int i = 0; i < 2 * NUM_LAYERS; i++) begin
            reg_write(6'(i), {8'h00, ROWS[r].scroll[8*i +: 8]});
        end
        reg_write(6'(REG_ENABLE), {13'd0, ROWS[r].en});
        for (int k = 0; k < NUM_LAYERS; k++) begin
            cur_sx[k] = ROWS[r].scroll[16*k +: 8];
            cur_sy[k] = ROWS[r].scroll[16*k + 8 +: 8];
        end
        cur_en = ROWS[r].en;
        reg_write(6'(REG_IRQ_ACK), 16'h0000);
        check_eq("irq_n after ack", int'(irq_n), 1);
        end_test($sformatf("irq row %0d", r));
        if (ROWS[r].refill) begin
            start_test();
            refill_palette();
            end_test($sformatf("palette row %0d", r));
        end
        start_test();
        capture_frame();
        end_test($sformatf("frame row %0d", r));
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        cpu_addr = '0;
        cpu_dout = '0;
        cpu_we = 1'b0;
        regs_cs = 1'b0;
        pal_cs = 1'b0;
        lfsr_state = SEED;
        errors = 0;
        checks = 0;
        tests = 0;
        timed_out = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        start_test();
        check_eq("irq_n", int'(irq_n), 1);
        check_eq("de", int'(de), 0);
        check_eq("hs", int'(hs), 0);
        check_eq("vs", int'(vs), 0);
        end_test("reset");

        // the first vblank falls inside this frame, so clear it afterwards
        start_test();
        check_raster();
        reg_write(6'(REG_IRQ_ACK), 16'h0000);
        end_test("raster");

        for (int r = 0; r < NUM_ROWS; r++) begin
            if (!timed_out) run_row(r);
        end

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
logic/video_pkg.sv
logic/gfx_pkg.sv
logic/video_timing.sv
logic/layer_ctrl.sv
logic/tile_layer.sv
logic/color_mixer.sv
logic/video_top.sv
verif/video_tb.sv

// File: run.sh
#!/bin/sh
# build and run the video testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f files.f \
    --top-module video_tb \
    -Mdir obj_dir \
    -o video_sim

./obj_dir/video_sim > sim.log
cat sim.log

grep -q "ALL CHECKS PASSED" sim.log
echo "simulation passed"
